//--- logic/board_pkg.sv
// shared constants and enums for the board control block, imported by every RTL module
package board_pkg;

    // --------------------------------------------------
    // APB and register map
    // --------------------------------------------------
    localparam int ADDR_WIDTH = 12;                   // byte address, index in [5:2]

    typedef enum logic [3:0] {
        REG_STATUS  = 4'd0,                           // power, relay, amp enables
        REG_TIMEOUT = 4'd3,                           // watchdog period and led
        REG_VERSION = 4'd4,
        REG_TEMPSNS = 4'd5,                           // temperature sensor
        REG_DIGIN   = 4'd10,                          // limits, home, fault
        REG_DEBUG   = 4'd15                           // scratch
    } reg_addr_e;

    localparam logic [31:0] BOARD_VERSION = 32'h4243_3031;
    localparam logic [31:0] DEBUG_RESET   = 32'h0000_2000;

    // --------------------------------------------------
    // axes, tick and timers
    // --------------------------------------------------
    localparam int NUM_AXES   = 4;
    localparam int TICK_WIDTH = 4;                    // one tick every 16 clocks

    localparam logic [15:0] MV_SETTLE_TICKS   = 16'd8;
    localparam logic [15:0] WDOG_PERIOD_RESET = 16'h0000;  // zero means watchdog off
    localparam logic [15:0] WDOG_STEP         = 16'h0040;  // phase threshold step

    // period indicator shown on the led
    typedef enum logic [2:0] {
        WDOG_DISABLE,
        WDOG_PHASE_ONE,
        WDOG_PHASE_TWO,
        WDOG_PHASE_THREE,
        WDOG_PHASE_FOUR,
        WDOG_PHASE_FIVE
    } wdog_phase_e;

    // --------------------------------------------------
    // APB bridge FSM
    // --------------------------------------------------
    typedef enum logic [1:0] {
        IDLE,                                         // waiting for setup phase
        ACCESS,                                       // first access cycle
        READ_WAIT                                     // read data returned here
    } apb_state_e;

endpackage

//--- logic/apb_reg_bridge.sv
// APB slave port that turns each transfer into a single-cycle register read or write strobe
module apb_reg_bridge import board_pkg::*; (
    input  logic                  pclk,
    input  logic                  rst_n,
    input  logic                  psel,
    input  logic                  penable,
    input  logic                  pwrite,
    input  logic [ADDR_WIDTH-1:0] paddr,
    input  logic [31:0]           pwdata,
    output logic [31:0]           prdata,
    output logic                  pready,
    output logic                  pslverr,
    output logic [ADDR_WIDTH-1:0] reg_addr,
    output logic [31:0]           reg_wdata,
    output logic                  reg_wen,
    output logic                  reg_ren,
    input  logic [31:0]           reg_rdata
);

    apb_state_e state, state_next;
    logic       aligned;                              // word aligned address
    logic       access;                               // first access cycle seen

    assign aligned = (paddr[1:0] == 2'b00);
    assign access  = (state == ACCESS) && psel && penable;

    always_ff @(posedge pclk) begin
        if (!rst_n) begin
            state <= IDLE;
        end else begin
            state <= state_next;
        end
    end

    always_comb begin
        state_next = state;
        case (state)
            IDLE:      if (psel && !penable) state_next = ACCESS;    // setup phase
            ACCESS: begin
                if (!psel) begin
                    state_next = IDLE;                               // host gave up
                end else if (penable) begin
                    state_next = (pwrite || !aligned) ? IDLE : READ_WAIT;
                end
            end
            READ_WAIT: state_next = IDLE;
            default:   state_next = IDLE;
        endcase
    end

    // strobes only for aligned addresses
    assign reg_wen   = access && pwrite && aligned;
    assign reg_ren   = access && !pwrite && aligned;
    assign reg_addr  = paddr;
    assign reg_wdata = pwdata;

    // writes and errors finish at once, reads one cycle later
    assign pready  = (access && (pwrite || !aligned)) || (state == READ_WAIT);
    assign pslverr = access && !aligned;
    assign prdata  = (state == READ_WAIT) ? reg_rdata : 32'd0;  // registered in board_regs

    // --------------------------------------------------
    // checks
    // --------------------------------------------------
    // strobes last a single clock
    a_strobe_single: assert property (@(posedge pclk) disable iff (!rst_n)
        (reg_wen || reg_ren) |=> !(reg_wen || reg_ren));

    // one ready pulse per transfer, at most one wait state
    a_ready_once: assert property (@(posedge pclk) disable iff (!rst_n)
        $rose(psel && penable) |-> ##[0:1] pready ##1 !pready);

endmodule

//--- logic/board_regs.sv
// status/control register file with amp disable logic and read mux, driven by the APB bridge
module board_regs import board_pkg::*; (
    input  logic                  pclk,
    input  logic                  rst_n,
    input  logic [ADDR_WIDTH-1:0] reg_addr,
    input  logic [31:0]           reg_wdata,
    input  logic                  reg_wen,
    input  logic                  reg_ren,
    input  logic                  wdog_timeout,
    input  wdog_phase_e           wdog_phase,
    input  logic [NUM_AXES:1]     settle_disable,
    input  logic                  mv_good,            // motor voltage good
    input  logic                  mv_faultn,          // motor supply fault, active low
    input  logic                  relay,              // safety relay feedback
    input  logic [3:0]            board_id,           // rotary switch
    input  logic [15:0]           temp_sense,
    input  logic [NUM_AXES:1]     fault,
    input  logic [NUM_AXES:1]     neg_limit,
    input  logic [NUM_AXES:1]     pos_limit,
    input  logic [NUM_AXES:1]     home,
    input  logic [NUM_AXES:1]     safety_amp_disable,
    output logic [31:0]           reg_rdata,
    output logic [NUM_AXES:1]     amp_disable,        // to the amplifiers
    output logic                  pwr_enable,
    output logic                  relay_on,
    output logic                  any_write,
    output logic                  powerup_cmd,
    output logic [15:0]           wdog_period,
    output logic                  wdog_led
);

    reg_addr_e             idx;
    logic                  hit;                       // mapped, aligned word
    logic                  write_status;
    logic [NUM_AXES:1]     reg_disable;               // 1 = axis off
    logic [NUM_AXES:1]     en_mask;
    logic [NUM_AXES:1]     en_val;
    logic [NUM_AXES:1]     disable_wr;                // disable bits after a status write
    logic                  pwr_next;
    logic                  pwr_off;
    logic [31:0]           reg_debug;
    logic [31:0]           rd_mux;

    // --------------------------------------------------
    // decode
    // --------------------------------------------------
    assign idx          = reg_addr_e'(reg_addr[5:2]);
    assign hit          = (reg_addr[ADDR_WIDTH-1:6] == '0) && (reg_addr[1:0] == 2'b00);
    assign write_status = reg_wen && hit && (idx == REG_STATUS);

    assign en_mask  = reg_wdata[11:8];
    assign en_val   = reg_wdata[3:0];
    assign pwr_next = reg_wdata[19] ? reg_wdata[18] : pwr_enable;
    assign pwr_off  = !pwr_enable || !pwr_next;       // power off before or after write

    // masked bits take the new value, the rest hold
    assign disable_wr = {NUM_AXES{pwr_off}} | (en_mask & ~en_val) | (~en_mask & reg_disable);

    // host trying to bring up power or an amp
    assign powerup_cmd = write_status &&
                         ((reg_wdata[19] && reg_wdata[18]) || (|(en_mask & en_val)));
    assign any_write   = reg_wen;                     // restarts the watchdog

    assign amp_disable = reg_disable | settle_disable;

    // --------------------------------------------------
    // control registers
    // --------------------------------------------------
    always_ff @(posedge pclk) begin
        if (!rst_n) begin
            reg_disable <= '1;                        // all axes off
            pwr_enable  <= 1'b0;
            relay_on    <= 1'b0;
            wdog_led    <= 1'b0;
            wdog_period <= WDOG_PERIOD_RESET;
            reg_debug   <= DEBUG_RESET;
        end else if (reg_wen) begin
            if (hit) begin
                case (idx)
                    REG_STATUS: begin
                        reg_disable <= disable_wr;
                        relay_on    <= reg_wdata[17] ? reg_wdata[16] : relay_on;
                        pwr_enable  <= pwr_next;
                    end
                    REG_TIMEOUT: begin
                        wdog_led    <= reg_wdata[31];
                        wdog_period <= reg_wdata[15:0];
                    end
                    REG_DEBUG: reg_debug <= reg_wdata;
                    default: ;                        // read only or unmapped
                endcase
            end
        end else begin
            // timeout and safety inputs only ever turn axes off
            reg_disable <= reg_disable | safety_amp_disable | {NUM_AXES{wdog_timeout}};
        end
    end

    // --------------------------------------------------
    // read mux
    // --------------------------------------------------
    always_comb begin
        case (idx)
            REG_STATUS:  rd_mux = {4'd4, board_id,
                                   wdog_timeout, 3'b000,
                                   mv_good, pwr_enable, ~relay, relay_on,
                                   ~mv_faultn, 2'b00, wdog_led, fault,
                                   safety_amp_disable, ~reg_disable};
            REG_TIMEOUT: rd_mux = {wdog_led, 12'd0, wdog_phase, wdog_period};
            REG_VERSION: rd_mux = BOARD_VERSION;
            REG_TEMPSNS: rd_mux = {16'd0, temp_sense};
            REG_DIGIN:   rd_mux = {16'd0, neg_limit, pos_limit, home, fault};
            REG_DEBUG:   rd_mux = reg_debug;
            default:     rd_mux = 32'd0;
        endcase
    end

    // data ready for the bridge wait state
    always_ff @(posedge pclk) begin
        if (reg_ren) begin
            reg_rdata <= hit ? rd_mux : 32'd0;        // unmapped reads zero
        end
    end

    // power off keeps every amp off
    a_pwr_off_amps: assert property (@(posedge pclk) disable iff (!rst_n)
        (!pwr_enable && !reg_wen) |-> (amp_disable == '1));

endmodule

//--- logic/board_wdog.sv
// tick divider and host watchdog, raises a sticky timeout when the host stops writing
module board_wdog import board_pkg::*; (
    input  logic        pclk,
    input  logic        rst_n,
    input  logic        any_write,                    // any register write
    input  logic        powerup_cmd,                  // clears timeout
    input  logic [15:0] wdog_period,                  // in ticks, 0 = off
    output logic        tick,
    output logic        wdog_timeout,
    output wdog_phase_e wdog_phase
);

    logic [TICK_WIDTH-1:0] tick_cnt;
    logic [15:0]           wdog_count;

    // --------------------------------------------------
    // tick divider
    // --------------------------------------------------
    always_ff @(posedge pclk) begin
        if (!rst_n) begin
            tick_cnt <= '0;
        end else begin
            tick_cnt <= tick_cnt + 1'b1;              // free running
        end
    end

    assign tick = &tick_cnt;                          // one clock in 16

    // --------------------------------------------------
    // watchdog counter and sticky flag
    // --------------------------------------------------
    always_ff @(posedge pclk) begin
        if (!rst_n) begin
            wdog_count   <= 16'd0;
            wdog_timeout <= 1'b0;
        end else if (powerup_cmd) begin
            wdog_count   <= 16'd0;
            wdog_timeout <= 1'b0;
        end else if (any_write) begin
            wdog_count <= 16'd0;                      // host is alive
        end else if (tick && (wdog_period != 16'd0)) begin
            if (wdog_count < wdog_period) begin
                wdog_count <= wdog_count + 1'b1;
            end else begin
                wdog_timeout <= 1'b1;                 // stays set until power up
            end
        end
    end

    // period thresholds for the led indicator
    always_comb begin
        if (wdog_period == 16'd0) begin
            wdog_phase = WDOG_DISABLE;
        end else if (wdog_period <= WDOG_STEP) begin
            wdog_phase = WDOG_PHASE_ONE;
        end else if (wdog_period <= 16'(2 * WDOG_STEP)) begin
            wdog_phase = WDOG_PHASE_TWO;
        end else if (wdog_period <= 16'(3 * WDOG_STEP)) begin
            wdog_phase = WDOG_PHASE_THREE;
        end else if (wdog_period <= 16'(4 * WDOG_STEP)) begin
            wdog_phase = WDOG_PHASE_FOUR;
        end else begin
            wdog_phase = WDOG_PHASE_FIVE;
        end
    end

    a_no_timeout_off: assert property (@(posedge pclk) disable iff (!rst_n)
        $rose(wdog_timeout) |-> ($past(wdog_period) != 16'd0));

endmodule

//--- logic/power_settle.sv
// motor voltage settle timer, keeps the amps off until mv_good has held for the settle time
module power_settle import board_pkg::*; (
    input  logic                pclk,
    input  logic                rst_n,
    input  logic                tick,                 // from board_wdog
    input  logic                mv_good,
    output logic [NUM_AXES:1]   settle_disable
);

    logic [15:0] settle_cnt;                          // ticks with mv_good high

    always_ff @(posedge pclk) begin
        if (!rst_n) begin
            settle_cnt     <= 16'd0;
            settle_disable <= '1;
        end else if (!mv_good) begin
            settle_cnt     <= 16'd0;                  // start over
            settle_disable <= '1;
        end else if (tick) begin
            if (settle_cnt < MV_SETTLE_TICKS) begin
                settle_cnt <= settle_cnt + 1'b1;
            end else begin
                settle_disable <= '0;                 // settled, release amps
            end
        end
    end

    // loss of motor voltage turns all amps off next clock
    a_mv_loss: assert property (@(posedge pclk) disable iff (!rst_n)
        !mv_good |=> (settle_disable == '1));

endmodule

//--- logic/board_ctrl_top.sv
// top level of the board control block, wires the APB bridge to registers and timers
module board_ctrl_top import board_pkg::*; (
    input  logic                  pclk,
    input  logic                  rst_n,
    input  logic                  psel,
    input  logic                  penable,
    input  logic                  pwrite,
    input  logic [ADDR_WIDTH-1:0] paddr,
    input  logic [31:0]           pwdata,
    output logic [31:0]           prdata,
    output logic                  pready,
    output logic                  pslverr,
    input  logic                  mv_good,
    input  logic                  mv_faultn,
    input  logic                  relay,
    input  logic [3:0]            board_id,
    input  logic [15:0]           temp_sense,
    input  logic [NUM_AXES:1]     fault,
    input  logic [NUM_AXES:1]     neg_limit,
    input  logic [NUM_AXES:1]     pos_limit,
    input  logic [NUM_AXES:1]     home,
    input  logic [NUM_AXES:1]     safety_amp_disable,
    output logic [NUM_AXES:1]     amp_disable,
    output logic                  pwr_enable,
    output logic                  relay_on,
    output logic                  wdog_timeout
);

    // --------------------------------------------------
    // internal nets
    // --------------------------------------------------
    logic [ADDR_WIDTH-1:0] reg_addr;
    logic [31:0]           reg_wdata;
    logic [31:0]           reg_rdata;
    logic                  reg_wen;
    logic                  reg_ren;
    logic                  any_write;
    logic                  powerup_cmd;
    logic [15:0]           wdog_period;
    wdog_phase_e           wdog_phase;
    logic                  tick;                      // every 16 clocks
    logic [NUM_AXES:1]     settle_disable;

    apb_reg_bridge u_bridge (.*);

    // led output not brought out on this board
    board_regs u_regs (
        .wdog_led (),
        .*
    );

    board_wdog u_wdog (.*);

    power_settle u_settle (.*);

endmodule

//--- tests/tb_clk_gen.sv
// clock and reset source for the board control testbench, instantiated once by tb_board_ctrl
module tb_clk_gen (
    output logic pclk,
    output logic rst_n
);

    localparam int HALF_PERIOD  = 10;                 // 20 unit period
    localparam int RESET_CYCLES = 10;

    initial begin
        pclk = 1'b0;
        forever #HALF_PERIOD pclk = ~pclk;
    end

    initial begin
        rst_n = 1'b0;
        repeat (RESET_CYCLES) @(posedge pclk);
        @(negedge pclk);
        rst_n = 1'b1;                                 // released away from the rising edge
    end

endmodule

//--- tests/tb_board_ctrl.sv
// testbench for board_ctrl_top, runs APB transfers and board inputs against a register mirror
module tb_board_ctrl import board_pkg::*; ();

    localparam int NUM_TESTS  = 6;
    localparam int TIME_LIMIT = NUM_TESTS * 2000 + 5000;
    localparam int TICK       = 16;                   // clocks per watchdog tick

    logic                  pclk, rst_n;
    logic                  psel, penable, pwrite;
    logic [ADDR_WIDTH-1:0] paddr;
    logic [31:0]           pwdata, prdata;
    logic                  pready, pslverr;
    logic                  mv_good, mv_faultn, relay;
    logic [3:0]            board_id;
    logic [15:0]           temp_sense;
    logic [NUM_AXES:1]     fault, neg_limit, pos_limit, home, safety_amp_disable;
    logic [NUM_AXES:1]     amp_disable;
    logic                  pwr_enable, relay_on, wdog_timeout;

    // mirror of what the host has written
    logic                  m_pwr, m_relay_on, m_led, m_timeout;
    logic [NUM_AXES:1]     m_disable;                 // 1 = axis off
    logic [15:0]           m_period;
    logic [31:0]           m_debug;

    int                    errors, checks;
    logic [31:0]           rd_data;                   // last transfer result
    logic                  rd_err;
    string                 cmp_name;
    logic [31:0]           cmp_exp, cmp_got;
    event                  cmp_ev;

    tb_clk_gen u_clk (.pclk(pclk), .rst_n(rst_n));

    board_ctrl_top DUT (.*);

    // --------------------------------------------------
    // reference model
    // --------------------------------------------------
    function automatic logic [ADDR_WIDTH-1:0] reg_byte(input logic [3:0] idx);
        return {6'd0, idx, 2'b00};
    endfunction

    function automatic logic [2:0] phase_of(input logic [15:0] period);
        int steps;
        steps = (int'(period) + int'(WDOG_STEP) - 1) / int'(WDOG_STEP);  // round up
        return (steps > 5) ? 3'd5 : 3'(steps);
    endfunction

    function automatic logic [31:0] expected_read(input logic [ADDR_WIDTH-1:0] addr);
        if (addr[11:6] != 6'd0) begin
            return 32'd0;                             // outside the map
        end
        case (addr[5:2])
            REG_STATUS:  return {4'd4, board_id, m_timeout, 3'b000, mv_good, m_pwr,
                                 ~relay, m_relay_on, ~mv_faultn, 2'b00, m_led, fault,
                                 safety_amp_disable, ~m_disable};
            REG_TIMEOUT: return {m_led, 12'd0, phase_of(m_period), m_period};
            REG_VERSION: return BOARD_VERSION;
            REG_TEMPSNS: return {16'd0, temp_sense};
            REG_DIGIN:   return {16'd0, neg_limit, pos_limit, home, fault};
            REG_DEBUG:   return m_debug;
            default:     return 32'd0;
        endcase
    endfunction

    task automatic check(input string name, input logic [31:0] exp, input logic [31:0] got);
        checks++;
        if (got !== exp) begin
            $display("FAILED %s exp=%h got=%h", name, exp, got);
            errors++;
        end
    endtask

    always @(cmp_ev) check(cmp_name, cmp_exp, cmp_got);  // read compare

    // --------------------------------------------------
    // APB host
    // --------------------------------------------------
    task automatic apb_transfer(input logic wr, input logic [ADDR_WIDTH-1:0] addr,
                                input logic [31:0] d);
        int waits;
        waits = 0;
        @(negedge pclk);
        psel    = 1'b1;                               // setup phase
        penable = 1'b0;
        pwrite  = wr;
        paddr   = addr;
        pwdata  = d;
        @(negedge pclk);
        penable = 1'b1;
        #1;                                           // sample mid cycle
        while (!pready && waits < 4) begin
            @(negedge pclk);
            #1;
            waits++;
        end
        if (!pready) begin
            $display("no pready from the DUT for address %h", addr);
            errors++;
        end
        rd_data = prdata;
        rd_err  = pslverr;
        @(negedge pclk);
        psel    = 1'b0;
        penable = 1'b0;
    endtask

    task automatic apb_write(input logic [ADDR_WIDTH-1:0] addr, input logic [31:0] d);
        apb_transfer(1'b1, addr, d);
    endtask

    task automatic apb_read(input string name, input logic [ADDR_WIDTH-1:0] addr);
        apb_transfer(1'b0, addr, 32'd0);
        check("pslverr", 32'd0, rd_err);              // aligned reads never error
        cmp_name = name;
        cmp_exp  = expected_read(addr);
        cmp_got  = rd_data;
        -> cmp_ev;
    endtask

    // mask/value rule with power off forcing every axis off
    task automatic status_write(input logic [31:0] d);
        logic pwr_before;
        pwr_before = m_pwr;
        if (d[19])
            m_pwr = d[18];
        if (d[17])
            m_relay_on = d[16];
        m_disable = (d[11:8] & ~d[3:0]) | (~d[11:8] & m_disable);
        if (!pwr_before || !m_pwr)
            m_disable = '1;
        if ((d[19] && d[18]) || |(d[11:8] & d[3:0]))
            m_timeout = 1'b0;                         // power up clears the watchdog
        apb_write(reg_byte(REG_STATUS), d);
    endtask

    initial begin
        #(TIME_LIMIT);
        $display("simulation timed out");
        $display("Some tests failed");
        $finish;
    end

    // --------------------------------------------------
    // stimulus
    // --------------------------------------------------
    initial begin
        logic [31:0] data;
        logic [3:0]  en;
        int          cycles;
        int          axis;
        void'($urandom(32'haca6_f997));
        psel = 1'b0;
        penable = 1'b0;
        pwrite = 1'b0;
        paddr = '0;
        pwdata = '0;
        mv_good = 1'b1;                               // supply good from the start
        mv_faultn = 1'b1;
        relay = 1'b0;
        board_id = '0;
        temp_sense = '0;
        {fault, neg_limit, pos_limit, home, safety_amp_disable} = '0;
        {m_pwr, m_relay_on, m_led, m_timeout} = '0;
        m_disable = '1;
        m_period = WDOG_PERIOD_RESET;
        m_debug = 32'h0000_2000;
        errors = 0;
        checks = 0;
        @(posedge rst_n);

        // 1 reset state
        apb_read("status", reg_byte(REG_STATUS));
        apb_read("timeout", reg_byte(REG_TIMEOUT));
        apb_read("version", reg_byte(REG_VERSION));
        apb_read("debug", reg_byte(REG_DEBUG));
        check("amp_disable", 32'hf, amp_disable);

        // 2 power control after the settle time
        repeat ((MV_SETTLE_TICKS + 2) * TICK) @(negedge pclk);
        status_write(32'h000C_0000);
        data = $urandom;
        en = 4'($urandom) | 4'b0001;                  // axis 1 always on
        status_write({14'd0, 1'b1, data[0], 4'd0, 4'hf, 4'd0, en});
        check("pwr_enable", m_pwr, pwr_enable);
        check("relay_on", m_relay_on, relay_on);
        check("amp_disable", m_disable, amp_disable);
        apb_read("status", reg_byte(REG_STATUS));
        for (int i = 0; i < 3; i++) begin
            m_debug = $urandom;
            apb_write(reg_byte(REG_DEBUG), m_debug);
            apb_read("debug", reg_byte(REG_DEBUG));
            data = $urandom;
            m_led = data[31];
            m_period = 16'(data[15:0] % 16'h0180);   // spans every phase
            apb_write(reg_byte(REG_TIMEOUT), {data[31:16], m_period});
            apb_read("timeout", reg_byte(REG_TIMEOUT));
        end
        m_period = 16'd0;                             // watchdog off again
        apb_write(reg_byte(REG_TIMEOUT), {m_led, 31'd0});

        // 3 read only inputs, unmapped and misaligned
        @(negedge pclk);
        board_id = 4'($urandom);
        temp_sense = 16'($urandom);
        {neg_limit, pos_limit, home, fault} = 16'($urandom);
        mv_faultn = 1'($urandom);
        relay = 1'($urandom);
        apb_read("status", reg_byte(REG_STATUS));
        apb_read("tempsns", reg_byte(REG_TEMPSNS));
        apb_read("digin", reg_byte(REG_DIGIN));
        apb_read("unmapped", 12'h004);
        apb_read("unmapped", 12'h040);
        apb_transfer(1'b1, 12'h002, 32'h000F_0F00);  // would turn every amp off if decoded
        check("pslverr", 32'd1, rd_err);
        apb_read("status", reg_byte(REG_STATUS));

        // 4 settle timer
        @(negedge pclk);
        mv_good = 1'b0;
        @(negedge pclk);
        check("amp_disable", 32'hf, amp_disable);
        mv_good = 1'b1;
        cycles = 0;
        while (amp_disable == 4'hf && cycles < (MV_SETTLE_TICKS + 2) * TICK) begin
            @(negedge pclk);
            cycles++;
        end
        if (amp_disable == 4'hf || cycles < MV_SETTLE_TICKS * TICK) begin
            $display("amps released after %0d clocks, outside the settle window", cycles);
            errors++;
        end
        check("amp_disable", m_disable, amp_disable);

        // 5 watchdog
        m_period = 16'd4;
        apb_write(reg_byte(REG_TIMEOUT), {m_led, 15'd0, m_period});
        cycles = 0;
        while (!wdog_timeout && cycles < (4 + 2) * TICK) begin
            @(negedge pclk);
            cycles++;
        end
        if (!wdog_timeout) begin
            $display("watchdog did not time out within %0d clocks", cycles);
            errors++;
        end
        @(negedge pclk);                              // disable bits follow a clock later
        m_timeout = 1'b1;
        m_disable = '1;
        check("amp_disable", m_disable, amp_disable);
        apb_read("status", reg_byte(REG_STATUS));
        apb_read("timeout", reg_byte(REG_TIMEOUT));
        status_write(32'h000C_0000);
        check("wdog_timeout", 32'd0, wdog_timeout);
        for (int i = 0; i < 4; i++) begin
            repeat (2 * TICK) @(negedge pclk);        // half the period
            check("wdog_timeout", 32'd0, wdog_timeout);
            m_debug = $urandom;
            apb_write(reg_byte(REG_DEBUG), m_debug);
        end
        m_period = 16'd0;
        apb_write(reg_byte(REG_TIMEOUT), {m_led, 31'd0});

        // 6 safety input on one axis
        status_write(32'h0000_0F0F);
        axis = $urandom_range(1, NUM_AXES);
        @(negedge pclk);
        safety_amp_disable[axis] = 1'b1;
        @(negedge pclk);
        m_disable[axis] = 1'b1;
        check("amp_disable", m_disable, amp_disable);
        apb_read("status", reg_byte(REG_STATUS));

        repeat (2) @(negedge pclk);
        $display("checks: %0d  errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

//--- compile.f
logic/board_pkg.sv
logic/apb_reg_bridge.sv
logic/board_regs.sv
logic/board_wdog.sv
logic/power_settle.sv
logic/board_ctrl_top.sv
tests/tb_clk_gen.sv
tests/tb_board_ctrl.sv
